/* files.f */
rtl/weight_pkg.sv
rtl/weight_apb_port.sv
rtl/weight_addr_gen.sv
rtl/weight_bank.sv
rtl/weight_read_format.sv
rtl/weight_memory_top.sv
tests/weight_memory_chk.sv
tests/weight_memory_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= weight_memory_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/weight_memory_tb.sv */
`timescale 1ns/1ps

module weight_memory_tb import weight_pkg::*; ();

	localparam int N_DIM         = 4;
	localparam int WEIGHT_W      = 8;
	localparam int ADDR_W        = 11;
	localparam int LANE_W        = $clog2(N_DIM);
	localparam int WORD_W        = N_DIM * WEIGHT_W;
	localparam int TILE_W        = N_DIM * WORD_W;
	localparam int WORDS         = 2 ** ADDR_W;
	localparam int DRAIN_TIMEOUT = 16;
	localparam int N_OPS         = 40;
	localparam int N_READS       = 160;

	logic                 clk;
	logic                 reset;
	logic                 PSEL;
	logic                 PENABLE;
	logic                 PWRITE;
	logic [15:0]          PADDR;
	logic [31:0]          PWDATA;
	logic [31:0]          PRDATA;
	logic                 PSLVERR;
	logic                 rd_valid;
	logic [ADDR_W-1:0]    rd_addr;
	logic                 read_valid;
	logic [TILE_W-1:0]    read_word;

	logic [31:0]          lfsr;
	logic [WORD_W-1:0]    model_mem [WORDS];
	weight_mode_e         model_mode;
	logic [ADDR_W-1:0]    model_ptr;
	logic [TILE_W-1:0]    exp_q [$];
	int                   checks;

	// refill schedule for the bank split phase
	logic                 op_ctrl [N_OPS];
	logic [ADDR_W-1:0]    op_idx [N_OPS];
	logic [31:0]          op_data [N_OPS];
	logic [ADDR_W-1:0]    rd_list [N_READS];

	weight_memory_top #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W), .ADDR_W(ADDR_W)) weight_memory_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// memory model, writes land at the edge ending the access phase
	always @(posedge clk) begin
		if (reset && PSEL && PENABLE && PWRITE && PADDR[15])
			model_mem[PADDR[ADDR_W+1:2]] <= PWDATA[WORD_W-1:0];
	end

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			model_mode <= MODE_FC;
			model_ptr  <= '0;
		end else if (PSEL && PENABLE && PWRITE && !PADDR[15]) begin
			if (PADDR == REG_CTRL)
				model_mode <= weight_mode_e'(PWDATA[0]);
			else if (PADDR == REG_POINTER)
				model_ptr <= PWDATA[ADDR_W-1:0];
		end
	end

	function automatic logic [TILE_W-1:0] expect_tile(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] eff;
		logic [TILE_W-1:0] t;
		eff = addr + model_ptr;
		t   = '0;
		if (model_mode == MODE_FC) begin
			eff[LANE_W-1:0] = '0; // tile start
			for (int k = 0; k < N_DIM; k++)
				t[k*WORD_W +: WORD_W] = model_mem[eff + ADDR_W'(k)];
		end else begin
			t[WORD_W-1:0] = model_mem[eff];
		end
		return t;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input logic [TILE_W-1:0] exp, input logic [TILE_W-1:0] got);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t read_word expected %h got %h", $time, exp, got);
			fail_now("read result differs from the memory model");
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			fail_now("register readback is wrong");
		end
	endtask

	task automatic check_err(input logic exp, input logic got);
		if (got !== exp) begin
			$display("[ERROR] %0t PSLVERR expected %b got %b", $time, exp, got);
			fail_now("wrong APB error response");
		end
	endtask

	task automatic check_mode(input weight_mode_e exp, input weight_mode_e got);
		if (got !== exp) begin
			$display("[ERROR] %0t mode expected %s got %s", $time, exp.name(), got.name());
			fail_now("mode readback is wrong");
		end
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, input logic exp_err);
		@(negedge clk);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b1;
		PADDR   = addr;
		PWDATA  = data;
		@(negedge clk);
		PENABLE = 1'b1;
		#1;
		check_err(exp_err, PSLVERR);
		@(negedge clk);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, input logic exp_err, output logic [31:0] data);
		@(negedge clk);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
		PADDR   = addr;
		@(negedge clk);
		PENABLE = 1'b1;
		#1;
		check_err(exp_err, PSLVERR);
		data = PRDATA;
		@(negedge clk);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic issue_read(input logic [ADDR_W-1:0] addr);
		@(negedge clk);
		rd_valid = 1'b1;
		rd_addr  = addr;
		exp_q.push_back(expect_tile(addr));
	endtask

	task automatic stop_reads;
		@(negedge clk);
		rd_valid = 1'b0;
	endtask

	task automatic drain_reads;
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			if (n == DRAIN_TIMEOUT) begin
				fail_now("timeout waiting for outstanding read results");
			end else begin
				@(posedge clk);
				n++;
			end
		end
	endtask

	// results must come back in issue order
	always @(negedge clk) begin
		if (reset && read_valid) begin
			if (exp_q.size() == 0)
				fail_now("read_valid rose with no read outstanding");
			else
				check_word(exp_q.pop_front(), read_word);
		end
	end

	initial begin
		logic [31:0] v;
		logic [31:0] data;
		logic [15:0] a;
		logic        rd_bank;
		lfsr     = 32'h66d0_bca0;
		checks   = 0;
		reset    = 1'b0;
		PSEL     = 1'b0;
		PENABLE  = 1'b0;
		PWRITE   = 1'b0;
		PADDR    = '0;
		PWDATA   = '0;
		rd_valid = 1'b0;
		rd_addr  = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;

		// register access
		if (read_valid !== 1'b0)
			fail_now("read_valid is not low after reset");
		check_word('0, read_word);
		apb_read(REG_CTRL, 1'b0, data);
		check_mode(MODE_FC, weight_mode_e'(data[0]));
		check_reg("PRDATA", 32'h0, data);
		apb_read(REG_POINTER, 1'b0, data);
		check_reg("PRDATA", 32'h0, data);
		repeat (8) begin
			take_bits(32, v);
			apb_write(REG_CTRL, v, 1'b0);
			apb_read(REG_CTRL, 1'b0, data);
			check_mode(weight_mode_e'(v[0]), weight_mode_e'(data[0]));
			check_reg("PRDATA", {31'b0, v[0]}, data);
			take_bits(32, v);
			apb_write(REG_POINTER, v, 1'b0);
			apb_read(REG_POINTER, 1'b0, data);
			check_reg("PRDATA", 32'(v[ADDR_W-1:0]), data);
		end

		// error responses
		repeat (8) begin
			take_bits(ADDR_W, v);
			apb_read(WEIGHT_WINDOW | 16'({v[ADDR_W-1:0], 2'b00}), 1'b1, data);
			take_bits(15, v);
			a = {1'b0, v[14:0]};
			if (a == REG_CTRL || a == REG_POINTER)
				a = 16'h0008;
			apb_read(a, 1'b1, data);
			apb_write(a, 32'hffff_ffff, 1'b1);
		end
		apb_read(REG_POINTER, 1'b0, data);
		check_reg("PRDATA", 32'(model_ptr), data); // unmapped writes must not move it

		// fill the whole store
		for (int i = 0; i < WORDS; i++) begin
			take_bits(32, v);
			apb_write(WEIGHT_WINDOW | 16'(i << 2), v, 1'b0);
		end

		// FC then CNN, random pointers, back to back reads
		for (int m = 0; m < 2; m++) begin
			apb_write(REG_CTRL, 32'(m), 1'b0);
			repeat (4) begin
				take_bits(ADDR_W, v);
				apb_write(REG_POINTER, v, 1'b0);
				repeat (64) begin
					take_bits(ADDR_W, v);
					issue_read(v[ADDR_W-1:0]);
				end
				stop_reads();
				drain_reads();
			end
		end

		// CNN reads across the end of the space
		apb_write(REG_POINTER, 32'h7fc, 1'b0);
		for (int i = 0; i < 8; i++)
			issue_read(ADDR_W'(i));
		stop_reads();
		drain_reads();

		// refill one half while the other streams, mode flips in between
		for (int half = 0; half < 2; half++) begin
			rd_bank = (half == 1);
			for (int i = 0; i < N_OPS; i++) begin
				take_bits(2, v);
				op_ctrl[i] = (v[1:0] == 2'b00);
				take_bits(ADDR_W - 1, v);
				op_idx[i] = {!rd_bank, v[ADDR_W-2:0]};
				take_bits(32, v);
				op_data[i] = v;
			end
			for (int i = 0; i < N_READS; i++) begin
				take_bits(ADDR_W - 1, v);
				rd_list[i] = {rd_bank, v[ADDR_W-2:0]};
			end
			fork
				for (int i = 0; i < N_OPS; i++) begin
					if (op_ctrl[i])
						apb_write(REG_CTRL, {31'b0, op_data[i][0]}, 1'b0);
					else
						apb_write(WEIGHT_WINDOW | 16'({op_idx[i], 2'b00}), op_data[i], 1'b0);
				end
				begin
					for (int i = 0; i < N_READS; i++)
						issue_read(rd_list[i] - model_ptr);
					stop_reads();
				end
			join
			drain_reads();
		end

		if (checks > 0 && exp_q.size() == 0 && weight_memory_top_i.chk_i.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_now("assertion failures or no read results were checked");
		end
	end

endmodule

/* tests/weight_memory_chk.sv */
`timescale 1ns/1ps

module weight_memory_chk import weight_pkg::*; #(
	parameter int  N_DIM    = 4,
	parameter int  WEIGHT_W = 8,
	localparam int WORD_W   = N_DIM * WEIGHT_W,
	localparam int TILE_W   = N_DIM * WORD_W
) (
	input logic              clk,
	input logic              reset,
	input logic              rd_valid,
	input logic              read_valid,
	input logic [TILE_W-1:0] read_word,
	input weight_mode_e      s1_mode
);

	int unsigned fail_count = 0;

	// fixed three cycle pipe
	assert property (@(posedge clk) disable iff (!reset) rd_valid |-> ##3 read_valid)
		else begin fail_count++; $error("read_valid missing 3 cycles after rd_valid"); end

	assert property (@(posedge clk) disable iff (!reset) read_valid |-> $past(rd_valid, 3))
		else begin fail_count++; $error("read_valid without a read 3 cycles earlier"); end

	assert property (@(posedge clk) !reset |-> !read_valid)
		else begin fail_count++; $error("read_valid high during reset"); end

	// s1_mode two edges back is the mode this result was issued with
	assert property (@(posedge clk) disable iff (!reset)
		(read_valid && $past(s1_mode, 2) == MODE_CNN) |-> read_word[TILE_W-1:WORD_W] == '0)
		else begin fail_count++; $error("CNN result has nonzero upper rows"); end

endmodule

bind weight_memory_top weight_memory_chk #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W)) chk_i (
	.clk(clk),
	.reset(reset),
	.rd_valid(rd_valid),
	.read_valid(read_valid),
	.read_word(read_word),
	.s1_mode(s1_mode)
);

/* rtl/weight_memory_top.sv */
`timescale 1ns/1ps

module weight_memory_top import weight_pkg::*; #(
	parameter int N_DIM    = 4,
	parameter int WEIGHT_W = 8,
	parameter int ADDR_W   = 11
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             PSEL,
	input  logic                             PENABLE,
	input  logic                             PWRITE,
	input  logic [15:0]                      PADDR,
	input  logic [31:0]                      PWDATA,
	output logic [31:0]                      PRDATA,
	output logic                             PSLVERR,
	input  logic                             rd_valid,
	input  logic [ADDR_W-1:0]                rd_addr,
	output logic                             read_valid,
	output logic [N_DIM*N_DIM*WEIGHT_W-1:0] read_word
);

	localparam int LANE_W = $clog2(N_DIM);
	localparam int ROW_W  = ADDR_W - 1 - LANE_W;
	localparam int WORD_W = N_DIM * WEIGHT_W;
	localparam int TILE_W = N_DIM * WORD_W;

	weight_mode_e      mode;
	logic [ADDR_W-1:0] pointer;
	logic [1:0]        wr_en_bank;
	logic [ADDR_W-2:0] wr_addr;
	logic [WORD_W-1:0] wr_data;

	logic              s1_valid;
	weight_mode_e      s1_mode;
	logic              s1_bank;
	logic [ROW_W-1:0]  s1_row;
	logic [LANE_W-1:0] s1_lane;
	logic [TILE_W-1:0] bank0_data;
	logic [TILE_W-1:0] bank1_data;

	weight_apb_port #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W), .ADDR_W(ADDR_W)) apb_port_i (
		.clk(clk), .reset(reset),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PSLVERR(PSLVERR),
		.mode(mode), .pointer(pointer),
		.wr_en_bank(wr_en_bank), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	weight_addr_gen #(.N_DIM(N_DIM), .ADDR_W(ADDR_W)) addr_gen_i (
		.clk(clk), .reset(reset),
		.rd_valid(rd_valid), .rd_addr(rd_addr), .mode(mode), .pointer(pointer),
		.s1_valid(s1_valid), .s1_mode(s1_mode), .s1_bank(s1_bank),
		.s1_row(s1_row), .s1_lane(s1_lane)
	);

	// only the addressed bank reads, the other half stays free for refill
	weight_bank #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W), .ADDR_W(ADDR_W)) bank0_i (
		.clk(clk),
		.wr_en(wr_en_bank[0]), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(s1_valid && !s1_bank), .rd_row(s1_row), .rd_data(bank0_data)
	);

	weight_bank #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W), .ADDR_W(ADDR_W)) bank1_i (
		.clk(clk),
		.wr_en(wr_en_bank[1]), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(s1_valid && s1_bank), .rd_row(s1_row), .rd_data(bank1_data)
	);

	weight_read_format #(.N_DIM(N_DIM), .WEIGHT_W(WEIGHT_W)) read_format_i (
		.clk(clk), .reset(reset),
		.s1_valid(s1_valid), .s1_mode(s1_mode), .s1_bank(s1_bank), .s1_lane(s1_lane),
		.bank0_data(bank0_data), .bank1_data(bank1_data),
		.read_valid(read_valid), .read_word(read_word)
	);

endmodule

/* rtl/weight_read_format.sv */
`timescale 1ns/1ps

module weight_read_format import weight_pkg::*; #(
	parameter int  N_DIM    = 4,
	parameter int  WEIGHT_W = 8,
	localparam int LANE_W   = $clog2(N_DIM),
	localparam int WORD_W   = N_DIM * WEIGHT_W,
	localparam int TILE_W   = N_DIM * WORD_W
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              s1_valid,
	input  weight_mode_e      s1_mode,
	input  logic              s1_bank,
	input  logic [LANE_W-1:0] s1_lane,
	input  logic [TILE_W-1:0] bank0_data,
	input  logic [TILE_W-1:0] bank1_data,
	output logic              read_valid,
	output logic [TILE_W-1:0] read_word
);

	logic              s2_valid;
	weight_mode_e      s2_mode;
	logic              s2_bank;
	logic [LANE_W-1:0] s2_lane;
	logic [TILE_W-1:0] row_data;
	logic [TILE_W-1:0] word_next;

	// tags follow the bank read by one cycle
	always_ff @(posedge clk) begin
		s2_mode <= s1_mode;
		s2_bank <= s1_bank;
		s2_lane <= s1_lane;
	end

	assign row_data = s2_bank ? bank1_data : bank0_data;

	always_comb begin
		word_next = '0;
		if (s2_valid) begin
			if (s2_mode == MODE_FC)
				word_next = row_data;
			else
				word_next[WORD_W-1:0] = row_data[s2_lane*WORD_W +: WORD_W]; // row 0 only
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			s2_valid   <= 1'b0;
			read_valid <= 1'b0;
			read_word  <= '0;
		end else begin
			s2_valid   <= s1_valid;
			read_valid <= s2_valid;
			read_word  <= word_next;
		end
	end

endmodule

/* rtl/weight_bank.sv */
`timescale 1ns/1ps

module weight_bank #(
	parameter int  N_DIM    = 4,
	parameter int  WEIGHT_W = 8,
	parameter int  ADDR_W   = 11,
	localparam int LANE_W   = $clog2(N_DIM),
	localparam int ROW_W    = ADDR_W - 1 - LANE_W,
	localparam int WORD_W   = N_DIM * WEIGHT_W,
	localparam int DEPTH    = 2 ** ROW_W
) (
	input  logic                    clk,
	input  logic                    wr_en,
	input  logic [ADDR_W-2:0]       wr_addr,
	input  logic [WORD_W-1:0]       wr_data,
	input  logic                    rd_en,
	input  logic [ROW_W-1:0]        rd_row,
	output logic [N_DIM*WORD_W-1:0] rd_data
);

	logic [WORD_W-1:0] mem [N_DIM][DEPTH]; // one array per lane
	logic [LANE_W-1:0] wr_lane;
	logic [ROW_W-1:0]  wr_row;

	assign wr_lane = wr_addr[LANE_W-1:0];
	assign wr_row  = wr_addr[ADDR_W-2:LANE_W];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_lane][wr_row] <= wr_data;
		// whole row at once, lane k into slot k
		if (rd_en) begin
			for (int k = 0; k < N_DIM; k++)
				rd_data[k*WORD_W +: WORD_W] <= mem[k][rd_row];
		end
	end

endmodule

/* rtl/weight_addr_gen.sv */
`timescale 1ns/1ps

module weight_addr_gen import weight_pkg::*; #(
	parameter int    N_DIM  = 4,
	parameter int    ADDR_W = 11,
	localparam int   LANE_W = $clog2(N_DIM),
	localparam int   ROW_W  = ADDR_W - 1 - LANE_W
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              rd_valid,
	input  logic [ADDR_W-1:0] rd_addr,
	input  weight_mode_e      mode,
	input  logic [ADDR_W-1:0] pointer,
	output logic              s1_valid,
	output weight_mode_e      s1_mode,
	output logic              s1_bank,
	output logic [ROW_W-1:0]  s1_row,
	output logic [LANE_W-1:0] s1_lane
);

	logic [ADDR_W-1:0] eff_addr;
	logic [ADDR_W-1:0] aligned_addr;

	assign eff_addr = rd_addr + pointer; // wraps mod 2^ADDR_W

	always_comb begin
		aligned_addr = eff_addr;
		if (mode == MODE_FC)
			aligned_addr[LANE_W-1:0] = '0; // snap to tile start
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= rd_valid;
	end

	// tags only move on an accepted read
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			s1_mode <= mode;
			s1_bank <= aligned_addr[ADDR_W-1];
			s1_row  <= aligned_addr[ADDR_W-2:LANE_W];
			s1_lane <= aligned_addr[LANE_W-1:0];
		end
	end

endmodule

/* rtl/weight_apb_port.sv */
`timescale 1ns/1ps

module weight_apb_port import weight_pkg::*; #(
	parameter int N_DIM    = 4,
	parameter int WEIGHT_W = 8,
	parameter int ADDR_W   = 11
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      PSEL,
	input  logic                      PENABLE,
	input  logic                      PWRITE,
	input  logic [15:0]               PADDR,
	input  logic [31:0]               PWDATA,
	output logic [31:0]               PRDATA,
	output logic                      PSLVERR,
	output weight_mode_e              mode,
	output logic [ADDR_W-1:0]         pointer,
	output logic [1:0]                wr_en_bank,
	output logic [ADDR_W-2:0]         wr_addr,
	output logic [N_DIM*WEIGHT_W-1:0] wr_data
);

	logic              access;
	logic              in_window;
	logic              win_write;
	logic              reg_hit;
	logic [ADDR_W-1:0] word_idx;

	assign access    = PSEL && PENABLE; // no wait states
	assign in_window = (PADDR & WEIGHT_WINDOW) != 16'h0000;
	assign win_write = access && PWRITE && in_window;
	assign word_idx  = PADDR[ADDR_W+1:2];

	// register decode and readback
	always_comb begin
		reg_hit = 1'b0;
		PRDATA  = '0;
		case (PADDR)
			REG_CTRL: begin
				reg_hit = 1'b1;
				PRDATA  = {31'b0, mode};
			end
			REG_POINTER: begin
				reg_hit = 1'b1;
				PRDATA  = {{(32-ADDR_W){1'b0}}, pointer};
			end
			default: reg_hit = 1'b0;
		endcase
		if (!access || PWRITE || in_window)
			PRDATA = '0; // only driven for register reads
	end

	// window is write-only, anything else off the map errors
	assign PSLVERR = access && (in_window ? !PWRITE : !reg_hit);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			mode    <= MODE_FC;
			pointer <= '0;
		end else if (access && PWRITE && !in_window) begin
			case (PADDR)
				REG_CTRL:    mode    <= weight_mode_e'(PWDATA[0]);
				REG_POINTER: pointer <= PWDATA[ADDR_W-1:0];
				default:     pointer <= pointer;
			endcase
		end
	end

	// top bit of the word index picks the bank
	assign wr_en_bank = {win_write && word_idx[ADDR_W-1], win_write && !word_idx[ADDR_W-1]};
	assign wr_addr    = word_idx[ADDR_W-2:0];
	assign wr_data    = PWDATA[N_DIM*WEIGHT_W-1:0];

endmodule

/* rtl/weight_pkg.sv */
package weight_pkg;

	// read mode, captured per read by the address generator
	typedef enum logic {
		MODE_FC  = 1'b0, // full 4-word tile
		MODE_CNN = 1'b1  // single word in row 0
	} weight_mode_e;

	// APB register offsets
	// CTRL: bit 0 is the read mode
	// POINTER: low ADDR_W bits offset every read address
	typedef enum logic [15:0] {
		REG_CTRL    = 16'h0000,
		REG_POINTER = 16'h0004
	} weight_reg_e;

	// PADDR bit 15 set selects the weight window
	// word index then sits in PADDR[ADDR_W+1:2]
	localparam logic [15:0] WEIGHT_WINDOW = 16'h8000;

endpackage
